// File: include/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// datapath and pc width
`define DATA_W 32

// credits granted at reset, matches execute buffer depth
`define ISSUE_CREDITS 2

// credit counter width, must hold ISSUE_CREDITS
`define CREDIT_W 2

`endif

// File: design/isa_pkg.sv
package isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_LOAD_FP  = 7'b0000111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_CIN_INT  = 7'b0010100,  // custom port input
        OPC_OUT      = 7'b0010101,  // custom port output
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_STORE_FP = 7'b0100111,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_MADD     = 7'b1000011,
        OPC_MSUB     = 7'b1000111,
        OPC_NMSUB    = 7'b1001011,
        OPC_NMADD    = 7'b1001111,
        OPC_OP_FP    = 7'b1010011,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011   // csrrw only
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_I    = 3'b000,
        IMM_S    = 3'b001,
        IMM_B    = 3'b010,
        IMM_J    = 3'b011,
        IMM_UIMM = 3'b100,  // shift amount, zero extended
        IMM_U    = 3'b101
    } imm_src_e;

    typedef enum logic [2:0] {
        RES_ALU  = 3'b000,
        RES_MEM  = 3'b001,
        RES_PC4  = 3'b010,
        RES_CSR  = 3'b011,
        RES_UIMM = 3'b100,  // lui
        RES_FPU  = 3'b110,
        RES_IN   = 3'b111   // input port
    } result_src_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one fetched word, viewed per format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

// File: design/pipe_pkg.sv
`include "decode_consts.svh"

package pipe_pkg;

    // field order follows the main decoder control word
    typedef struct packed {
        logic                 reg_write;
        isa_pkg::imm_src_e    imm_src;
        logic                 alu_src;
        logic                 mem_read;
        logic                 mem_write;
        isa_pkg::result_src_e result_src;
        logic                 branch;
        logic [1:0]           alu_op;
        logic                 jump;
        logic                 c_reg_write;    // csr write
        logic                 out_issued;     // port output
        logic                 in_issued;      // port input
        logic                 fpu_dispatch;
        logic                 fpu_reg_write;  // fp register file write
        logic                 write_src;      // store data from fp regs
        logic                 s_fpu;          // fp side of the pipe
        logic                 illegal;
    } ctrl_t;

    typedef struct packed {
        ctrl_t              ctrl;
        logic [3:0]         alu_control;
        logic [`DATA_W-1:0] imm;
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic [4:0]         rs2;
        logic [4:0]         rs3;  // fused fp ops only
        logic [`DATA_W-1:0] pc;
    } decoded_t;

endpackage

// File: design/main_decoder.sv
`timescale 1ns/1ps

module main_decoder (
    input  isa_pkg::opcode_e opcode,
    input  logic [2:0]       funct3,
    input  logic             funct7_6,
    output pipe_pkg::ctrl_t  ctrl
);

    // reg_write imm_src alu_src mem_read mem_write result_src branch alu_op jump
    // c_reg_write out_issued in_issued fpu_dispatch fpu_reg_write write_src s_fpu
    logic [20:0] controls;
    logic        illegal;

    assign ctrl = {controls, illegal};

    always_comb begin
        illegal = 1'b0;
        case (opcode)
            isa_pkg::OPC_LOAD:
                controls = 21'b1_000_1_1_0_001_0_00_0_0_0_0_0_0_0_0;  // lw
            isa_pkg::OPC_STORE:
                controls = 21'b0_001_1_0_1_000_0_00_0_0_0_0_0_0_0_0;  // sw
            isa_pkg::OPC_CIN_INT:
                controls = 21'b1_000_0_0_0_111_0_00_0_0_0_1_0_0_0_0;
            isa_pkg::OPC_OUT:
                controls = 21'b0_000_0_0_0_000_0_00_0_0_1_0_0_0_0_0;
            isa_pkg::OPC_AUIPC:
                controls = 21'b1_101_1_0_0_000_0_11_0_0_0_0_0_0_0_0;
            isa_pkg::OPC_OP:
                controls = 21'b1_000_0_0_0_000_0_10_0_0_0_0_0_0_0_0;  // r-type
            isa_pkg::OPC_LUI:
                controls = 21'b1_101_0_0_0_100_0_00_0_0_0_0_0_0_0_0;
            isa_pkg::OPC_BRANCH:
                controls = 21'b0_010_0_0_0_000_1_01_0_0_0_0_0_0_0_0;
            isa_pkg::OPC_OP_IMM: begin
                // slli, srli and srai take a shift amount
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    controls = 21'b1_100_1_0_0_000_0_10_0_0_0_0_0_0_0_0;
                end else begin
                    controls = 21'b1_000_1_0_0_000_0_10_0_0_0_0_0_0_0_0;
                end
            end
            isa_pkg::OPC_JALR:
                controls = 21'b1_000_1_0_0_010_0_10_1_0_0_0_0_0_0_0;
            isa_pkg::OPC_JAL:
                controls = 21'b1_011_0_0_0_010_0_00_1_0_0_0_0_0_0_0;
            isa_pkg::OPC_SYSTEM:
                controls = 21'b1_000_0_0_0_011_0_00_0_1_0_0_0_0_0_0;  // csrrw
            isa_pkg::OPC_MADD,
            isa_pkg::OPC_MSUB,
            isa_pkg::OPC_NMSUB,
            isa_pkg::OPC_NMADD:
                controls = 21'b0_000_0_0_0_110_0_00_0_0_0_0_1_1_0_1;  // fused
            isa_pkg::OPC_OP_FP: begin
                if (funct7_6) begin
                    // compare and classify write the integer file
                    controls = 21'b1_000_0_0_0_110_0_00_0_0_0_0_1_0_0_1;
                end else begin
                    controls = 21'b0_000_0_0_0_110_0_00_0_0_0_0_1_1_0_1;
                end
            end
            isa_pkg::OPC_LOAD_FP:
                controls = 21'b0_000_1_1_0_001_0_00_0_0_0_0_0_1_0_0;  // flw
            isa_pkg::OPC_STORE_FP:
                controls = 21'b0_001_1_0_1_110_0_00_0_0_0_0_0_0_1_1;  // fsw
            default: begin
                controls = '0;
                illegal  = 1'b1;  // unknown opcode
            end
        endcase
    end

endmodule

// File: design/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder (
    input  logic [1:0] alu_op,
    input  logic [2:0] funct3,
    input  logic       funct7_5,
    input  logic       r_type,
    output logic [3:0] alu_control
);

    // codes understood by the execute stage ALU
    localparam logic [3:0] ALU_ADD  = 4'b0000;
    localparam logic [3:0] ALU_SUB  = 4'b0001;
    localparam logic [3:0] ALU_AND  = 4'b0010;
    localparam logic [3:0] ALU_OR   = 4'b0011;
    localparam logic [3:0] ALU_XOR  = 4'b0100;
    localparam logic [3:0] ALU_SLT  = 4'b0101;
    localparam logic [3:0] ALU_SLL  = 4'b0110;
    localparam logic [3:0] ALU_SRL  = 4'b0111;
    localparam logic [3:0] ALU_SRA  = 4'b1000;
    localparam logic [3:0] ALU_SLTU = 4'b1001;

    always_comb begin
        case (alu_op)
            2'b01: alu_control = ALU_SUB;  // branch compare
            2'b10: begin
                case (funct3)
                    3'b000:  alu_control = (r_type && funct7_5) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_control = ALU_SLL;
                    3'b010:  alu_control = ALU_SLT;
                    3'b011:  alu_control = ALU_SLTU;
                    3'b100:  alu_control = ALU_XOR;
                    3'b101:  alu_control = funct7_5 ? ALU_SRA : ALU_SRL;  // shifts
                    3'b110:  alu_control = ALU_OR;
                    default: alu_control = ALU_AND;
                endcase
            end
            default: alu_control = ALU_ADD;  // loads, stores, auipc
        endcase
    end

endmodule

// File: design/imm_extend.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module imm_extend (
    input  isa_pkg::instr_u   inst,
    input  isa_pkg::imm_src_e imm_src,
    output logic [`DATA_W-1:0] imm
);

    always_comb begin
        case (imm_src)
            isa_pkg::IMM_I:
                imm = {{(`DATA_W-12){inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            isa_pkg::IMM_S:
                imm = {{(`DATA_W-12){inst.s_fmt.imm_11_5[6]}},
                       inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
            isa_pkg::IMM_B:
                imm = {{(`DATA_W-12){inst.b_fmt.imm_12}}, inst.b_fmt.imm_11,
                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            isa_pkg::IMM_J:
                imm = {{(`DATA_W-20){inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12,
                       inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            isa_pkg::IMM_UIMM:
                imm = {{(`DATA_W-5){1'b0}}, inst.i_fmt.imm_11_0[4:0]};  // shamt
            isa_pkg::IMM_U:
                imm = {inst.u_fmt.imm_31_12, {(`DATA_W-20){1'b0}}};
            default:
                imm = '0;
        endcase
    end

endmodule

// File: design/issue_credit.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module issue_credit (
    input  logic               clk,
    input  logic               rst_n,
    input  pipe_pkg::decoded_t in_op,
    input  logic               in_valid,
    output logic               in_ready,
    input  logic               credit_return,
    output pipe_pkg::decoded_t op,
    output logic               op_valid
);

    logic [`CREDIT_W-1:0] credits;  // free slots downstream
    logic                 issue;

    assign in_ready = (credits != '0);
    assign issue    = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits  <= `CREDIT_W'(`ISSUE_CREDITS);
            op_valid <= 1'b0;
        end else begin
            op_valid <= issue;  // one cycle per accepted word
            case ({issue, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // none, or both cancel
            endcase
        end
    end

    // payload only, qualified by op_valid
    always_ff @(posedge clk) begin
        if (issue) begin
            op <= in_op;
        end
    end

endmodule

// File: design/decode_top.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_top (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::instr_u    inst,
    input  logic [`DATA_W-1:0] pc,
    input  logic               inst_valid,
    output logic               inst_ready,
    output pipe_pkg::decoded_t op,
    output logic               op_valid,
    input  logic               credit_return
);

    pipe_pkg::ctrl_t    ctrl;
    logic [3:0]         alu_control;
    logic [`DATA_W-1:0] imm;
    pipe_pkg::decoded_t dec_op;

    main_decoder u_main_decoder (
        .opcode   (inst.r_fmt.opcode),
        .funct3   (inst.r_fmt.funct3),
        .funct7_6 (inst.r_fmt.funct7[6]),
        .ctrl     (ctrl)
    );

    alu_decoder u_alu_decoder (
        .alu_op      (ctrl.alu_op),
        .funct3      (inst.r_fmt.funct3),
        .funct7_5    (inst.r_fmt.funct7[5]),
        .r_type      (inst.r_fmt.opcode[5]),  // set for OP, clear for OP-IMM
        .alu_control (alu_control)
    );

    imm_extend u_imm_extend (
        .inst    (inst),
        .imm_src (ctrl.imm_src),
        .imm     (imm)
    );

    assign dec_op.ctrl        = ctrl;
    assign dec_op.alu_control = alu_control;
    assign dec_op.imm         = imm;
    assign dec_op.rd          = inst.r_fmt.rd;
    assign dec_op.rs1         = inst.r_fmt.rs1;
    assign dec_op.rs2         = inst.r_fmt.rs2;
    assign dec_op.rs3         = inst.r_fmt.funct7[6:2];  // bits 31:27
    assign dec_op.pc          = pc;

    issue_credit u_issue_credit (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_op         (dec_op),
        .in_valid      (inst_valid),
        .in_ready      (inst_ready),
        .credit_return (credit_return),
        .op            (op),
        .op_valid      (op_valid)
    );

endmodule

// File: verif/tb_decode_top.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module tb_decode_top;

    localparam int STALL_LIMIT = 50;  // cycles an entry may wait
    localparam int HOLD_CYCLES = 4;   // stall length for held entries

    typedef struct packed {
        logic [31:0]         word;
        logic [`DATA_W-1:0]  pc;
        pipe_pkg::ctrl_t     ctrl;
        logic [3:0]          alu;
        logic [`DATA_W-1:0]  imm;
        logic                hold;  // no credit returns while waiting
    } entry_t;

    logic               clk;
    logic               rst_n;
    isa_pkg::instr_u    inst;
    logic [`DATA_W-1:0] pc;
    logic               inst_valid;
    logic               inst_ready;
    pipe_pkg::decoded_t op;
    logic               op_valid;
    logic               credit_return;

    entry_t      tbl[$];
    entry_t      exp_e;
    logic        exp_valid;
    logic        accept;
    logic        hold_now;
    logic        timed_out;
    logic        saw_stall;
    logic [31:0] lcg_state;
    logic [31:0] rnd;
    int          credits;  // model of the issue credit count
    int          idx;
    int          stall;
    int          ctrl_errs;
    int          alu_errs;
    int          word_errs;
    int          reg_errs;
    int          flow_errs;

    decode_top u_decode_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst          (inst),
        .pc            (pc),
        .inst_valid    (inst_valid),
        .inst_ready    (inst_ready),
        .op            (op),
        .op_valid      (op_valid),
        .credit_return (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic ctrl_cmp(input string name, input pipe_pkg::ctrl_t expv,
                            input pipe_pkg::ctrl_t actv);
        if (actv !== expv) begin
            $display("ERR %0t %s exp=%h act=%h", $time, name, expv, actv);
            ctrl_errs++;
        end
    endtask

    task automatic alu_cmp(input string name, input logic [3:0] expv, input logic [3:0] actv);
        if (actv !== expv) begin
            $display("ERR %0t %s exp=%h act=%h", $time, name, expv, actv);
            alu_errs++;
        end
    endtask

    task automatic word_cmp(input string name, input logic [`DATA_W-1:0] expv,
                            input logic [`DATA_W-1:0] actv);
        if (actv !== expv) begin
            $display("ERR %0t %s exp=%h act=%h", $time, name, expv, actv);
            word_errs++;
        end
    endtask

    task automatic reg_cmp(input string name, input logic [4:0] expv, input logic [4:0] actv);
        if (actv !== expv) begin
            $display("ERR %0t %s exp=%0d act=%0d", $time, name, expv, actv);
            reg_errs++;
        end
    endtask

    task automatic flag_cmp(input string name, input logic expv, input logic actv);
        if (actv !== expv) begin
            $display("ERR %0t %s exp=%b act=%b", $time, name, expv, actv);
            flow_errs++;
        end
    endtask

    // register fields come straight from the R-type bit positions
    task automatic op_cmp(input entry_t e);
        ctrl_cmp("op.ctrl", e.ctrl, op.ctrl);
        alu_cmp("op.alu_control", e.alu, op.alu_control);
        word_cmp("op.imm", e.imm, op.imm);
        word_cmp("op.pc", e.pc, op.pc);
        reg_cmp("op.rd", e.word[11:7], op.rd);
        reg_cmp("op.rs1", e.word[19:15], op.rs1);
        reg_cmp("op.rs2", e.word[24:20], op.rs2);
        reg_cmp("op.rs3", e.word[31:27], op.rs3);
    endtask

    task automatic add_entry(input logic [31:0] word, input pipe_pkg::ctrl_t ctrl,
                             input logic [3:0] alu, input logic [31:0] imm, input logic hold);
        entry_t e;
        e.word = word;
        e.pc   = 32'h0000_1000 + 32'(tbl.size() * 4);
        e.ctrl = ctrl;
        e.alu  = alu;
        e.imm  = imm;
        e.hold = hold;
        tbl.push_back(e);
    endtask

    // ctrl: rw imm_src {alu_src mem_rd mem_wr} res br alu_op jmp {c o i fd fw ws s} ill
    task automatic build_table();
        add_entry(32'hFFC12283, 22'b1_000_110_001_0_00_0_0000000_0, 4'h0, 32'hFFFFFFFC, 0);
        add_entry(32'hFE61AC23, 22'b0_001_101_000_0_00_0_0000000_0, 4'h0, 32'hFFFFFFF8, 0);
        add_entry(32'h003100B3, 22'b1_000_000_000_0_10_0_0000000_0, 4'h0, 32'h00000003, 0);
        add_entry(32'h403100B3, 22'b1_000_000_000_0_10_0_0000000_0, 4'h1, 32'h00000403, 0);
        add_entry(32'h4062D233, 22'b1_000_000_000_0_10_0_0000000_0, 4'h8, 32'h00000406, 0);
        add_entry(32'h009463B3, 22'b1_000_000_000_0_10_0_0000000_0, 4'h3, 32'h00000009, 0);
        add_entry(32'h0075D513, 22'b1_100_100_000_0_10_0_0000000_0, 4'h7, 32'h00000007, 0);
        add_entry(32'h4075D513, 22'b1_100_100_000_0_10_0_0000000_0, 4'h8, 32'h00000007, 0);
        add_entry(32'hFFB6A613, 22'b1_000_100_000_0_10_0_0000000_0, 4'h5, 32'hFFFFFFFB, 0);
        add_entry(32'h0F07F713, 22'b1_000_100_000_0_10_0_0000000_0, 4'h2, 32'h000000F0, 0);
        add_entry(32'h1238C813, 22'b1_000_100_000_0_10_0_0000000_0, 4'h4, 32'h00000123, 0);
        add_entry(32'h40010093, 22'b1_000_100_000_0_10_0_0000000_0, 4'h0, 32'h00000400, 0);
        add_entry(32'hABCDE1B7, 22'b1_101_000_100_0_00_0_0000000_0, 4'h0, 32'hABCDE000, 1);
        add_entry(32'h12345217, 22'b1_101_100_000_0_11_0_0000000_0, 4'h0, 32'h12345000, 1);
        add_entry(32'hFE2088E3, 22'b0_010_000_000_1_01_0_0000000_0, 4'h1, 32'hFFFFFFF0, 1);
        add_entry(32'h00419A63, 22'b0_010_000_000_1_01_0_0000000_0, 4'h1, 32'h00000014, 0);
        add_entry(32'h001000EF, 22'b1_011_000_010_0_00_1_0000000_0, 4'h0, 32'h00000800, 0);
        add_entry(32'hFFDFF06F, 22'b1_011_000_010_0_00_1_0000000_0, 4'h0, 32'hFFFFFFFC, 0);
        add_entry(32'h00C280E7, 22'b1_000_100_010_0_10_1_0000000_0, 4'h0, 32'h0000000C, 0);
        add_entry(32'h30039373, 22'b1_000_000_011_0_00_0_1000000_0, 4'h0, 32'h00000300, 0);
        add_entry(32'h00000414, 22'b1_000_000_111_0_00_0_0010000_0, 4'h0, 32'h00000000, 0);
        add_entry(32'h00048015, 22'b0_000_000_000_0_00_0_0100000_0, 4'h0, 32'h00000000, 0);
        add_entry(32'h01012087, 22'b0_000_110_001_0_00_0_0000100_0, 4'h0, 32'h00000010, 0);
        add_entry(32'h02322227, 22'b0_001_101_110_0_00_0_0000011_0, 4'h0, 32'h00000024, 0);
        add_entry(32'h203100C3, 22'b0_000_000_110_0_00_0_0001101_0, 4'h0, 32'h00000203, 0);
        add_entry(32'h007302D3, 22'b0_000_000_110_0_00_0_0001101_0, 4'h0, 32'h00000007, 0);
        add_entry(32'hA020A553, 22'b1_000_000_110_0_00_0_0001001_0, 4'h0, 32'hFFFFFA02, 0);
        add_entry(32'h0000007F, 22'b0_000_000_000_0_00_0_0000000_1, 4'h0, 32'h00000000, 0);
    endtask

    initial begin
        rst_n         = 1'b0;
        inst          = '0;
        pc            = '0;
        inst_valid    = 1'b0;
        credit_return = 1'b0;
        lcg_state     = 32'h8e78ed0e;
        credits       = `ISSUE_CREDITS;
        exp_valid     = 1'b0;
        timed_out     = 1'b0;
        saw_stall     = 1'b0;
        idx           = 0;
        stall         = 0;
        ctrl_errs     = 0;
        alu_errs      = 0;
        word_errs     = 0;
        reg_errs      = 0;
        flow_errs     = 0;
        build_table();
        repeat (8) @(posedge clk);
        rst_n      <= 1'b1;
        inst       <= tbl[0].word;
        pc         <= tbl[0].pc;
        inst_valid <= 1'b1;
        while ((idx < tbl.size() || exp_valid) && !timed_out) begin
            @(negedge clk);
            flag_cmp("op_valid", exp_valid, op_valid);
            if (exp_valid) begin
                op_cmp(exp_e);
            end
            flag_cmp("inst_ready", credits != 0, inst_ready);
            accept = inst_valid && (credits != 0);
            if (inst_valid && !inst_ready) begin
                saw_stall = 1'b1;
            end
            if (accept && !credit_return) begin
                credits = credits - 1;
            end else if (!accept && credit_return) begin
                credits = credits + 1;
            end
            exp_valid = accept;
            if (accept) begin
                exp_e = tbl[idx];
            end
            @(posedge clk);
            if (accept) begin
                idx   = idx + 1;
                stall = 0;
            end else begin
                stall = stall + 1;
            end
            if (idx < tbl.size()) begin
                inst       <= tbl[idx].word;
                pc         <= tbl[idx].pc;
                inst_valid <= 1'b1;
            end else begin
                inst_valid <= 1'b0;
            end
            hold_now = (idx < tbl.size()) && tbl[idx].hold && (stall < HOLD_CYCLES);
            rnd      = lcg_next();
            credit_return <= !hold_now && (credits < `ISSUE_CREDITS) && rnd[31];
            if (stall > STALL_LIMIT) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("timeout: entry %0d was not accepted within %0d cycles", idx, STALL_LIMIT);
        end
        if (!saw_stall) begin
            $display("inst_ready never fell while an instruction waited, no back-pressure seen");
            flow_errs++;
        end
        $display("error counts: ctrl=%0d alu=%0d word=%0d reg=%0d flow=%0d",
                 ctrl_errs, alu_errs, word_errs, reg_errs, flow_errs);
        if (!timed_out && (ctrl_errs + alu_errs + word_errs + reg_errs + flow_errs) == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/main_decoder.sv
design/alu_decoder.sv
design/imm_extend.sv
design/issue_credit.sv
design/decode_top.sv
verif/tb_decode_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_decode_top
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# the log decides pass or fail, tee would hide the exit status
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
